// File: pattern_tester.f
+incdir+src
src/test_engine_pkg.sv
src/host_proto_pkg.sv
src/vec_store_if.sv
src/uart_rx.sv
src/uart_tx.sv
src/vector_store.sv
src/drive_sequencer.sv
src/tester_ctrl.sv
src/pattern_tester.sv
verification/pattern_tester_props.sv
verification/pattern_tester_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module pattern_tester_tb \
	-Mdir obj_dir -f pattern_tester.f > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vpattern_tester_tb > sim.log 2>&1
cat sim.log
grep -q "TEST RESULT: PASS" sim.log && exit 0 || exit 1

// File: src/drive_sequencer.sv
`timescale 1ns/1ps

module drive_sequencer (
	input  logic                       CLK,
	input  logic                       rst,
	input  logic                       clear,
	input  logic                       run,
	input  host_proto_pkg::cycle_cfg_s cfg,
	vec_store_if.reader                store,
	output test_engine_pkg::vector_t   signals,
	output logic                       cs_bar,
	output logic                       counter_clk,
	output logic                       done
);

	logic       active;
	logic [7:0] count;
	logic       cycle_end;
	logic       load;

	////////////////////////////////////////
	// Test cycle timing.
	////////////////////////////////////////

	assign cycle_end = active && (count == cfg.cycle_length);

	// First vector on the cycle after run rises, then one per test cycle.
	assign load = (run && !active && !store.empty) || (cycle_end && !store.empty);
	assign store.rd_en = load;

	// Address counter steps at the end of every test cycle.
	assign counter_clk = cycle_end;
	assign done = cycle_end && store.empty;

	// Chip select window, leading edge inclusive.
	assign cs_bar = !(active && (count >= cfg.leading_edge) && (count < cfg.trailing_edge));

	always_ff @(posedge CLK) begin
		if (rst || clear) begin
			active <= 1'b0;
			count <= 8'd0;
			signals <= '0;
		end else if (load) begin
			signals <= store.rd_data;
			count <= 8'd0;
			active <= 1'b1;
		end else if (done || !run) begin
			active <= 1'b0;
			count <= 8'd0;
		end else if (active) begin
			count <= count + 8'd1;
		end
	end

endmodule

// File: src/host_proto_pkg.sv
package host_proto_pkg;

	// Command bytes sent by the host.
	typedef enum logic [7:0] {
		CMD_INPUT_VECTOR = 8'h49,
		CMD_CYCLE_CONFIG = 8'h43,
		CMD_EXECUTE      = 8'h58
	} cmd_e;

	// Response bytes returned to the host.
	typedef enum logic [7:0] {
		RSP_ACK          = 8'h06,
		RSP_UNKNOWN_CODE = 8'h3F,
		RSP_NO_VECTORS   = 8'h15
	} rsp_e;

	// Test cycle timing, leading_edge sits in the low byte.
	typedef struct packed {
		logic [7:0] reserved;
		logic [7:0] cycle_length;
		logic [7:0] trailing_edge;
		logic [7:0] leading_edge;
	} cycle_cfg_s;

	// Assembled payload word, read as a vector or as a configuration.
	typedef union packed {
		test_engine_pkg::vector_t vec;
		cycle_cfg_s               cfg;
	} host_word_u;

endpackage

// File: src/pattern_tester.sv
`timescale 1ns/1ps
`include "tester_consts.svh"

module pattern_tester (
	input  logic                     CLK,
	input  logic                     rst,
	input  logic                     rx,
	output logic                     tx,
	output logic                     cs_bar,
	output logic                     counter_clk,
	output logic                     counter_rst,
	output test_engine_pkg::vector_t signals
);
	import host_proto_pkg::*;

	logic       [7:0] rx_byte;
	logic             rx_valid;
	logic       [7:0] tx_byte;
	logic             tx_start;
	logic             tx_busy;
	logic             run;
	logic             clear;
	logic             done;
	cycle_cfg_s       cfg;

	vec_store_if store_if ();

	// Host link.
	uart_rx #(
		.CLKS_PER_BIT(`CLKS_PER_BIT)
	) u_uart_rx (
		.CLK       (CLK),
		.rst       (rst),
		.rx        (rx),
		.data      (rx_byte),
		.byte_valid(rx_valid)
	);

	uart_tx #(
		.CLKS_PER_BIT(`CLKS_PER_BIT)
	) u_uart_tx (
		.CLK  (CLK),
		.rst  (rst),
		.data (tx_byte),
		.start(tx_start),
		.tx   (tx),
		.busy (tx_busy)
	);

	tester_ctrl u_ctrl (
		.CLK        (CLK),
		.rst        (rst),
		.rx_byte    (rx_byte),
		.rx_valid   (rx_valid),
		.tx_byte    (tx_byte),
		.tx_start   (tx_start),
		.tx_busy    (tx_busy),
		.store      (store_if.writer),
		.run        (run),
		.clear      (clear),
		.cfg        (cfg),
		.done       (done),
		.counter_rst(counter_rst)
	);

	vector_store #(
		.DEPTH(`VEC_DEPTH)
	) u_store (
		.CLK  (CLK),
		.rst  (rst),
		.clear(clear),
		.store(store_if.store)
	);

	drive_sequencer u_seq (
		.CLK        (CLK),
		.rst        (rst),
		.clear      (clear),
		.run        (run),
		.cfg        (cfg),
		.store      (store_if.reader),
		.signals    (signals),
		.cs_bar     (cs_bar),
		.counter_clk(counter_clk),
		.done       (done)
	);

endmodule

// File: src/test_engine_pkg.sv
`include "tester_consts.svh"

package test_engine_pkg;

	// One vector applied to the SIGNALS pins.
	typedef logic [`VEC_WIDTH-1:0] vector_t;

	// Central FSM states.
	typedef enum logic [4:0] {
		IDLE,
		DECODE,
		ACK_CMD,
		WAIT_ACK_SENT,
		COLLECT_PAYLOAD,
		STORE_PAYLOAD,
		RUN,
		TESTS_DONE,
		SEND_RSP,
		WAIT_RSP_SENT
	} ctrl_state_e;

endpackage

// File: src/tester_consts.svh
`ifndef TESTER_CONSTS_SVH
`define TESTER_CONSTS_SVH

// Bits per test vector.
`define VEC_WIDTH 32

// Number of vectors held by the on-chip store.
`define VEC_DEPTH 16

// Clocks per UART bit.
`define CLKS_PER_BIT 8

// Bytes in one host payload word, sent low byte first.
`define PAYLOAD_BYTES 4

`endif

// File: src/tester_ctrl.sv
`timescale 1ns/1ps
`include "tester_consts.svh"

module tester_ctrl (
	input  logic                       CLK,
	input  logic                       rst,
	input  logic [7:0]                 rx_byte,
	input  logic                       rx_valid,
	output logic [7:0]                 tx_byte,
	output logic                       tx_start,
	input  logic                       tx_busy,
	vec_store_if.writer                store,
	output logic                       run,
	output logic                       clear,
	output host_proto_pkg::cycle_cfg_s cfg,
	input  logic                       done,
	output logic                       counter_rst
);
	import test_engine_pkg::*;
	import host_proto_pkg::*;

	localparam int BYTE_CNT_W = $clog2(`PAYLOAD_BYTES);
	localparam int WORD_W = `PAYLOAD_BYTES * 8;
	localparam logic [BYTE_CNT_W-1:0] BYTE_LAST = BYTE_CNT_W'(`PAYLOAD_BYTES - 1);

	ctrl_state_e           state;
	ctrl_state_e           next_state;
	logic [7:0]            cmd_q;
	rsp_e                  rsp_q;
	host_word_u            word_q;
	logic [BYTE_CNT_W-1:0] byte_cnt;

	assign tx_start = (state == ACK_CMD) || (state == SEND_RSP);
	assign tx_byte = rsp_q;
	assign run = (state == RUN);
	assign clear = (state == TESTS_DONE);
	assign store.wr_en = (state == STORE_PAYLOAD) && (cmd_q == CMD_INPUT_VECTOR);
	assign store.wr_data = word_q.vec;

	////////////////////////////////////////
	// Next-state logic.
	////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (rx_valid) begin
					next_state = DECODE;
				end
			end
			DECODE: begin
				if (cmd_q == CMD_INPUT_VECTOR || cmd_q == CMD_CYCLE_CONFIG) begin
					next_state = ACK_CMD;
				end else if (cmd_q == CMD_EXECUTE && !store.empty) begin
					next_state = RUN;
				end else begin
					next_state = SEND_RSP;
				end
			end
			ACK_CMD: next_state = WAIT_ACK_SENT;
			WAIT_ACK_SENT: begin
				if (!tx_busy) begin
					next_state = COLLECT_PAYLOAD;
				end
			end
			COLLECT_PAYLOAD: begin
				if (rx_valid && byte_cnt == BYTE_LAST) begin
					next_state = STORE_PAYLOAD;
				end
			end
			STORE_PAYLOAD: next_state = SEND_RSP;
			RUN: begin
				if (done) begin
					next_state = TESTS_DONE;
				end
			end
			TESTS_DONE: next_state = SEND_RSP;
			SEND_RSP: next_state = WAIT_RSP_SENT;
			WAIT_RSP_SENT: begin
				if (!tx_busy) begin
					next_state = IDLE;
				end
			end
			default: next_state = IDLE;
		endcase
	end

	////////////////////////////////////////
	// Control registers.
	////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= IDLE;
			rsp_q <= RSP_ACK;
			cfg <= '0;
			byte_cnt <= '0;
			counter_rst <= 1'b1;
		end else begin
			state <= next_state;
			// Counter reset rides along with run start and with the soft clear.
			counter_rst <= (next_state == RUN && state != RUN) || (next_state == TESTS_DONE);
			case (state)
				DECODE: begin
					byte_cnt <= '0;
					if (cmd_q == CMD_INPUT_VECTOR || cmd_q == CMD_CYCLE_CONFIG) begin
						rsp_q <= RSP_ACK;
					end else if (cmd_q == CMD_EXECUTE) begin
						rsp_q <= RSP_NO_VECTORS;
					end else begin
						rsp_q <= RSP_UNKNOWN_CODE;
					end
				end
				COLLECT_PAYLOAD: begin
					if (rx_valid) begin
						byte_cnt <= byte_cnt + 1'b1;
					end
				end
				STORE_PAYLOAD: begin
					rsp_q <= RSP_ACK;
					if (cmd_q == CMD_CYCLE_CONFIG) begin
						cfg <= word_q.cfg;
					end
				end
				TESTS_DONE: begin
					cfg <= '0;
					rsp_q <= RSP_ACK;
				end
				default: begin
				end
			endcase
		end
	end

	// Command byte and payload word, low byte first.
	always_ff @(posedge CLK) begin
		if (state == IDLE && rx_valid) begin
			cmd_q <= rx_byte;
		end
		if (state == COLLECT_PAYLOAD && rx_valid) begin
			word_q <= {rx_byte, word_q[WORD_W-1:8]};
		end
	end

endmodule

// File: src/uart_rx.sv
`timescale 1ns/1ps
`include "tester_consts.svh"

module uart_rx #(
	parameter int CLKS_PER_BIT = `CLKS_PER_BIT
) (
	input  logic       CLK,
	input  logic       rst,
	input  logic       rx,
	output logic [7:0] data,
	output logic       byte_valid
);

	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

	localparam int CW = $clog2(CLKS_PER_BIT);
	localparam logic [CW-1:0] HALF = CW'(CLKS_PER_BIT / 2 - 1);
	localparam logic [CW-1:0] LAST = CW'(CLKS_PER_BIT - 1);

	rx_state_e     state;
	logic [1:0]    sync;
	logic [CW-1:0] clk_cnt;
	logic [2:0]    bit_idx;
	logic          sample;

	// Mid-bit sampling point of a data bit.
	assign sample = (state == RX_DATA) && (clk_cnt == LAST);

	always_ff @(posedge CLK) begin
		if (rst) begin
			sync <= 2'b11;
			state <= RX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			byte_valid <= 1'b0;
		end else begin
			sync <= {sync[0], rx};
			byte_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					clk_cnt <= '0;
					if (!sync[1]) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					// Recheck the line half a bit in, to reject glitches.
					if (clk_cnt == HALF) begin
						clk_cnt <= '0;
						bit_idx <= '0;
						state <= sync[1] ? RX_IDLE : RX_DATA;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (clk_cnt == LAST) begin
						clk_cnt <= '0;
						bit_idx <= bit_idx + 3'd1;
						if (bit_idx == 3'd7) begin
							state <= RX_STOP;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: begin
					if (clk_cnt == LAST) begin
						// Framing error drops the byte.
						byte_valid <= sync[1];
						state <= RX_IDLE;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
			endcase
		end
	end

	// LSB arrives first.
	always_ff @(posedge CLK) begin
		if (sample) begin
			data <= {sync[1], data[7:1]};
		end
	end

endmodule

// File: src/uart_tx.sv
`timescale 1ns/1ps
`include "tester_consts.svh"

module uart_tx #(
	parameter int CLKS_PER_BIT = `CLKS_PER_BIT
) (
	input  logic       CLK,
	input  logic       rst,
	input  logic [7:0] data,
	input  logic       start,
	output logic       tx,
	output logic       busy
);

	localparam int CW = $clog2(CLKS_PER_BIT);
	localparam logic [CW-1:0] LAST = CW'(CLKS_PER_BIT - 1);

	logic [8:0]    shreg;
	logic [CW-1:0] clk_cnt;
	logic [3:0]    bit_cnt;
	logic          bit_end;

	assign bit_end = busy && (clk_cnt == LAST);

	always_ff @(posedge CLK) begin
		if (rst) begin
			tx <= 1'b1;
			busy <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= '0;
		end else if (!busy) begin
			// Start bit goes out right away.
			if (start) begin
				tx <= 1'b0;
				busy <= 1'b1;
				clk_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (bit_end) begin
			clk_cnt <= '0;
			if (bit_cnt == 4'd9) begin
				busy <= 1'b0;
			end else begin
				tx <= shreg[0];
				bit_cnt <= bit_cnt + 4'd1;
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	// Data bits then the stop bit, shifted out LSB first.
	always_ff @(posedge CLK) begin
		if (!busy && start) begin
			shreg <= {1'b1, data};
		end else if (bit_end) begin
			shreg <= {1'b1, shreg[8:1]};
		end
	end

endmodule

// File: src/vec_store_if.sv
`timescale 1ns/1ps

interface vec_store_if;
	import test_engine_pkg::*;

	// Write side, one-cycle pulse pushes wr_data at the tail.
	logic    wr_en;
	vector_t wr_data;

	// Read side, rd_data always shows the head.
	logic    rd_en;
	vector_t rd_data;
	logic    empty;

	modport writer (
		output wr_en,
		output wr_data,
		input  empty
	);

	modport reader (
		output rd_en,
		input  rd_data,
		input  empty
	);

	modport store (
		input  wr_en,
		input  wr_data,
		input  rd_en,
		output rd_data,
		output empty
	);

endinterface

// File: src/vector_store.sv
`timescale 1ns/1ps
`include "tester_consts.svh"

module vector_store #(
	parameter int DEPTH = `VEC_DEPTH
) (
	input logic        CLK,
	input logic        rst,
	input logic        clear,
	vec_store_if.store store
);
	import test_engine_pkg::*;

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

	vector_t          mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             do_wr;
	logic             do_rd;

	assign full = (count == CNT_W'(DEPTH));
	assign store.empty = (count == '0);
	assign store.rd_data = mem[rd_ptr];

	// Writes to a full store are dropped.
	assign do_wr = store.wr_en && !full;
	assign do_rd = store.rd_en && !store.empty;

	always_ff @(posedge CLK) begin
		if (do_wr) begin
			mem[wr_ptr] <= store.wr_data;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: verification/pattern_tester_props.sv
`timescale 1ns/1ps

module pattern_tester_props (
	input logic                     CLK,
	input logic                     rst,
	input logic                     tx,
	input logic                     cs_bar,
	input logic                     counter_clk,
	input logic                     counter_rst,
	input test_engine_pkg::vector_t signals
);

	logic clk_seen;

	// Set by an address counter step, cleared by a counter reset.
	always_ff @(posedge CLK) begin
		if (rst || counter_rst) begin
			clk_seen <= 1'b0;
		end else if (counter_clk) begin
			clk_seen <= 1'b1;
		end
	end

	cs_idle_a: assert property (@(posedge CLK) disable iff (rst)
		(!clk_seen && signals == '0) |-> cs_bar)
		else $error("cs_bar low before any counter step with no vector driven");

	counter_clk_pulse_a: assert property (@(posedge CLK) disable iff (rst)
		counter_clk |=> !counter_clk)
		else $error("counter_clk high for two cycles in a row");

	tx_idle_a: assert property (@(posedge CLK) rst |=> tx)
		else $error("tx not idle high after reset");

endmodule

bind pattern_tester pattern_tester_props u_props (
	.CLK        (CLK),
	.rst        (rst),
	.tx         (tx),
	.cs_bar     (cs_bar),
	.counter_clk(counter_clk),
	.counter_rst(counter_rst),
	.signals    (signals)
);

// File: verification/pattern_tester_tb.sv
`timescale 1ns/1ps
`include "tester_consts.svh"

module pattern_tester_tb;
	import test_engine_pkg::*;
	import host_proto_pkg::*;

	localparam int CYCLE_LIMIT = 30000;
	localparam int START_TIMEOUT = 400;
	localparam int NUM_VECS = 3;
	localparam logic [7:0] LEAD = 8'd2;
	localparam logic [7:0] TRAIL = 8'd5;
	localparam logic [7:0] LENGTH = 8'd7;

	logic    CLK;
	logic    rst;
	logic    rx;
	logic    tx;
	logic    cs_bar;
	logic    counter_clk;
	logic    counter_rst;
	vector_t signals;

	int      value_errors;
	int      other_errors;
	int      cycle_count;
	integer  seed;
	vector_t sent_vecs [NUM_VECS];
	int      hold_clks [NUM_VECS];
	int      cs_low_clks [NUM_VECS];

	pattern_tester u_dut (
		.CLK        (CLK),
		.rst        (rst),
		.rx         (rx),
		.tx         (tx),
		.cs_bar     (cs_bar),
		.counter_clk(counter_clk),
		.counter_rst(counter_rst),
		.signals    (signals)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	////////////////////////////////////////
	// Reporting.
	////////////////////////////////////////

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		value_errors++;
		$display("ERR time=%0t signal=%s expected=%h actual=%h", $time, name, exp, got);
	endtask

	task automatic report_failure(input string what);
		other_errors++;
		$display("Failure at %0t: %s", $time, what);
	endtask

	task automatic close_run();
		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	endtask

	////////////////////////////////////////
	// Host side UART.
	////////////////////////////////////////

	task automatic send_byte(input logic [7:0] value);
		int i;
		@(negedge CLK);
		rx = 1'b0;
		repeat (`CLKS_PER_BIT) @(negedge CLK);
		for (i = 0; i < 8; i++) begin
			rx = value[i];
			repeat (`CLKS_PER_BIT) @(negedge CLK);
		end
		rx = 1'b1;
		repeat (`CLKS_PER_BIT) @(negedge CLK);
	endtask

	// Returns in the middle of the stop bit.
	task automatic recv_byte(output logic [7:0] value, output bit ok);
		int waited;
		int i;
		ok = 1'b0;
		value = '0;
		waited = 0;
		@(negedge CLK);
		while (tx !== 1'b0 && waited < START_TIMEOUT) begin
			@(negedge CLK);
			waited++;
		end
		if (tx !== 1'b0) begin
			report_failure("no start bit on tx within the wait limit");
		end else begin
			repeat (`CLKS_PER_BIT / 2) @(negedge CLK);
			for (i = 0; i < 8; i++) begin
				repeat (`CLKS_PER_BIT) @(negedge CLK);
				value[i] = tx;
			end
			repeat (`CLKS_PER_BIT) @(negedge CLK);
			if (tx !== 1'b1) begin
				report_failure("bad stop bit on tx");
			end else begin
				ok = 1'b1;
			end
		end
	endtask

	// The reply can start before the last host bit ends, so both run at once.
	task automatic expect_rsp(input logic [7:0] out_byte, input logic [7:0] exp,
			input string name);
		logic [7:0] got;
		bit         ok;
		fork
			send_byte(out_byte);
			recv_byte(got, ok);
		join
		if (ok) begin
			assert (got == exp) else report_mismatch(name, 32'(exp), 32'(got));
		end
	endtask

	task automatic send_payload(input logic [31:0] word);
		int b;
		for (b = 0; b < `PAYLOAD_BYTES - 1; b++) begin
			send_byte(word[8*b +: 8]);
		end
		expect_rsp(word[8*(`PAYLOAD_BYTES-1) +: 8], RSP_ACK, "tx ack after payload");
	endtask

	////////////////////////////////////////
	// Directed tests.
	////////////////////////////////////////

	task automatic refuse_empty_execute();
		expect_rsp(CMD_EXECUTE, RSP_NO_VECTORS, "tx reply to execute on empty store");
	endtask

	task automatic reject_unknown_byte();
		expect_rsp(8'h00, RSP_UNKNOWN_CODE, "tx reply to byte 00");
	endtask

	task automatic load_config_and_vectors();
		host_word_u word;
		int         k;
		word.cfg = '{reserved: 8'h00, cycle_length: LENGTH,
			trailing_edge: TRAIL, leading_edge: LEAD};
		expect_rsp(CMD_CYCLE_CONFIG, RSP_ACK, "tx ack to cycle config");
		send_payload(word);
		for (k = 0; k < NUM_VECS; k++) begin
			// Nonzero, so a vector never looks like the idle pins.
			sent_vecs[k] = $random(seed) | 32'h1;
			expect_rsp(CMD_INPUT_VECTOR, RSP_ACK, "tx ack to input vector");
			send_payload(sent_vecs[k]);
		end
	endtask

	task automatic execute_stored_vectors();
		logic [7:0] got;
		bit         ok;
		bit         rsp_done;
		int         idx;
		int         k;
		int         clk_pulses;
		int         rst_at_start;
		int         rst_at_end;
		idx = 0;
		clk_pulses = 0;
		rst_at_start = 0;
		rst_at_end = 0;
		rsp_done = 1'b0;
		for (k = 0; k < NUM_VECS; k++) begin
			hold_clks[k] = 0;
			cs_low_clks[k] = 0;
		end
		fork
			send_byte(CMD_EXECUTE);
			begin
				recv_byte(got, ok);
				rsp_done = 1'b1;
			end
			begin
				while (!rsp_done) begin
					@(negedge CLK);
					if (counter_rst) begin
						if (idx == 0 && hold_clks[0] == 0) begin
							rst_at_start++;
						end else if (idx == NUM_VECS) begin
							rst_at_end++;
						end else begin
							report_failure("counter_rst pulsed in the middle of the run");
						end
					end
					if (idx < NUM_VECS && signals != '0) begin
						assert (signals == sent_vecs[idx])
							else report_mismatch("signals", sent_vecs[idx], signals);
						hold_clks[idx]++;
						if (!cs_bar) begin
							cs_low_clks[idx]++;
						end
					end
					if (counter_clk) begin
						clk_pulses++;
						idx++;
					end
				end
			end
		join
		if (ok) begin
			assert (got == RSP_ACK) else report_mismatch("tx reply to execute", 32'(RSP_ACK), 32'(got));
		end
		for (k = 0; k < NUM_VECS; k++) begin
			assert (hold_clks[k] == int'(LENGTH) + 1)
				else report_mismatch("signals hold clocks", int'(LENGTH) + 1, hold_clks[k]);
		end
		assert (clk_pulses == NUM_VECS) else report_mismatch("counter_clk pulses", NUM_VECS, clk_pulses);
		assert (rst_at_start == 1) else report_mismatch("counter_rst at start", 1, rst_at_start);
		assert (rst_at_end == 1) else report_mismatch("counter_rst at end", 1, rst_at_end);
		@(negedge CLK);
		assert (signals == '0) else report_mismatch("signals after run", 0, signals);
	endtask

	// Uses the window lengths recorded during the run.
	task automatic verify_cs_window();
		int k;
		for (k = 0; k < NUM_VECS; k++) begin
			assert (cs_low_clks[k] == int'(TRAIL - LEAD))
				else report_mismatch("cs_bar low clocks", int'(TRAIL - LEAD), cs_low_clks[k]);
		end
	endtask

	task automatic confirm_store_cleared();
		expect_rsp(CMD_EXECUTE, RSP_NO_VECTORS, "tx reply to execute after clear");
	endtask

	////////////////////////////////////////
	// Sequence and watchdog.
	////////////////////////////////////////

	initial begin : watchdog
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge CLK);
			cycle_count++;
		end
		report_failure("cycle limit reached before the tests finished");
		close_run();
	end

	initial begin
		value_errors = 0;
		other_errors = 0;
		seed = 32'hba0e;
		rst = 1'b1;
		rx = 1'b1;
		repeat (2) @(negedge CLK);
		rst = 1'b0;
		refuse_empty_execute();
		reject_unknown_byte();
		load_config_and_vectors();
		execute_stored_vectors();
		verify_cs_window();
		confirm_store_cleared();
		close_run();
	end

endmodule
